// ==== list.f ====
logic/merge_pkg.sv
logic/record_fifo.sv
logic/sorter_cell.sv
logic/merge_node.sv
logic/merge_tree.sv
tests/merge_tree_tb.sv
+incdir+include

// ==== Makefile ====
# Verilator build and run of the merge tree testbench

VERILATOR ?= verilator
TOP       ?= merge_tree_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

PASS_TEXT := === PASS ===

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

$(SIM): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the exact pass line is printed
test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== include/merge_ref.svh ====
`ifndef MERGE_REF_SVH
`define MERGE_REF_SVH

// one stream of records in arrival order
typedef merge_pkg::record_t rec_q_t [$];

// 32-bit xorshift step
// state advances in place
function automatic logic [31:0] xorshift32(inout logic [31:0] state);
  state = state ^ (state << 13);
  state = state ^ (state >> 17);
  state = state ^ (state << 5);
  return state;
endfunction

function automatic merge_pkg::key_t key_of(input merge_pkg::record_t r);
  return r[merge_pkg::KEY_W-1:0];
endfunction

// terminator with a zero payload
function automatic merge_pkg::record_t terminator_rec();
  return {32'h0, merge_pkg::KEY_TERM};
endfunction

// one node
// strictly smaller left key wins and two terminators collapse into one
// records left after one side runs dry stay stuck as in the tree
function automatic rec_q_t merge_pair(input rec_q_t a, input rec_q_t b);
  rec_q_t out;
  while (a.size() > 0 && b.size() > 0) begin
    if (key_of(a[0]) == merge_pkg::KEY_TERM && key_of(b[0]) == merge_pkg::KEY_TERM) begin
      void'(a.pop_front());
      out.push_back(b.pop_front());
    end else if (key_of(a[0]) < key_of(b[0])) begin
      out.push_back(a.pop_front());
    end else begin
      out.push_back(b.pop_front());
    end
  end
  return out;
endfunction

// whole tree with pairs (2k, 2k+1) first and then level by level up to the root
function automatic rec_q_t expected_stream(input rec_q_t ways []);
  rec_q_t cur [];
  rec_q_t nxt [];
  cur = ways;
  while (cur.size() > 1) begin
    nxt = new[cur.size() / 2];
    for (int k = 0; k < cur.size() / 2; k++) begin
      nxt[k] = merge_pair(cur[2*k], cur[2*k+1]);
    end
    cur = nxt;
  end
  return cur[0];
endfunction

// n ascending random keys with random payloads and then a terminator
function automatic void append_random(inout rec_q_t q, inout logic [31:0] state,
                                      input int n);
  merge_pkg::key_t key;
  logic [31:0]     pay;
  key = '0;
  for (int i = 0; i < n; i++) begin
    key = key + merge_pkg::key_t'(xorshift32(state) % 32'd1000) + 1'b1;
    pay = xorshift32(state);
    q.push_back({pay, key});
  end
  q.push_back(terminator_rec());
endfunction

// fixed ramp of keys
// payload is tag plus index so equal keys stay traceable
function automatic void append_ramp(inout rec_q_t q, input merge_pkg::key_t first,
                                    input merge_pkg::key_t step, input int n,
                                    input logic [31:0] tag);
  for (int i = 0; i < n; i++) begin
    q.push_back({tag + 32'(i), first + step * merge_pkg::key_t'(i)});
  end
  q.push_back(terminator_rec());
endfunction

`endif

// ==== tests/merge_tree_tb.sv ====
`default_nettype none

module merge_tree_tb;
  import merge_pkg::*;

  `include "merge_ref.svh"

  localparam int WAY_LOG  = 2;
  localparam int FIFO_LOG = 2;
  localparam int WAYS     = 1 << WAY_LOG;
  localparam int DEPTH    = 1 << FIFO_LOG;

  // records per way in the tests without terminators
  localparam int N_RAND  = 6;
  localparam int N_EQ    = 5;
  localparam int N_LONG  = 12;
  localparam int N_FLOOD = 16;
  localparam int N_BATCH = 3;

  // all records sent over the whole run including terminators
  localparam int TOTAL_RECS = WAYS * (N_RAND + 1)
                            + WAYS * (N_EQ + 1)
                            + 1 + (N_LONG + 1) + (WAYS - 2) * (N_RAND + 1)
                            + WAYS * (N_RAND + 1)
                            + (N_FLOOD + 1) + (WAYS - 1) * (N_RAND + 1)
                            + N_BATCH * WAYS * (N_RAND + 1);
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_RECS + 200;
  localparam logic [31:0] SEED = 32'd96836;

  logic                CLK;
  logic                RST;
  beat_t               i_din;
  logic [WAY_LOG-1:0]  i_din_way;
  logic [WAYS-1:0]     o_way_ready;
  beat_t               o_dout;
  // back-pressure into the root
  logic                i_out_full = 1'b0;

  logic [31:0] rng;
  logic [31:0] bp_rng;
  logic [31:0] bp_word;
  logic        bp_on = 1'b0;
  logic        hold_full = 1'b0;
  rec_q_t      way_q [];
  rec_q_t      expect_q;
  record_t     exp_rec;
  record_t     rec_out;
  int          mismatch_errors = 0;
  int          other_errors = 0;
  int          accepted;

  merge_tree #(
    .WAY_LOG (WAY_LOG),
    .FIFO_LOG(FIFO_LOG)
  ) merge_tree_inst (
    .CLK        (CLK),
    .RST        (RST),
    .i_din      (i_din),
    .i_din_way  (i_din_way),
    .o_way_ready(o_way_ready),
    .o_dout     (o_dout),
    .i_out_full (i_out_full)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // random stall or a fixed hold on the falling edge
  always @(negedge CLK) begin
    if (bp_on) begin
      bp_word = xorshift32(bp_rng);
      i_out_full <= bp_word[0];
    end else begin
      i_out_full <= hold_full;
    end
  end

  // compare each output beat with the next expected record
  always @(posedge CLK) begin
    if (!RST && o_dout.valid) begin
      assert (!i_out_full) else begin
        other_errors++;
        $display("valid output beat at %0t while i_out_full is high", $time);
      end
      assert (expect_q.size() > 0) else begin
        other_errors++;
        $display("leftover record %h at %0t, nothing more was expected", o_dout.rec, $time);
      end
      if (expect_q.size() > 0) begin
        exp_rec = expect_q.pop_front();
        assert (o_dout.rec == exp_rec) else begin
          mismatch_errors++;
          $display("** Error at %0t: o_dout.rec = %h, expected %h", $time, o_dout.rec, exp_rec);
        end
      end
    end
  end

  // watchdog sized from the number of records in all tests
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge CLK);
    $display("run did not finish in %0d cycles, %0d records still missing",
             TIMEOUT_CYCLES, expect_q.size());
    print_summary();
    $display("=== FAIL ===");
    $finish;
  end

  task automatic print_summary();
    $display("errors: %0d wrong values, %0d other failures", mismatch_errors, other_errors);
  endtask

  function automatic int records_left();
    int n;
    n = 0;
    for (int w = 0; w < WAYS; w++) begin
      n += way_q[w].size();
    end
    return n;
  endfunction

  task automatic new_test(input string name);
    way_q = new[WAYS];
    $display("test: %s", name);
  endtask

  // one beat per cycle to a random ready way that has records left
  task automatic send_all();
    logic [31:0] r;
    int          start;
    int          w;
    int          pick;
    while (records_left() > 0) begin
      @(negedge CLK);
      r = xorshift32(rng);
      start = int'(r % WAYS);
      pick = -1;
      for (int k = 0; k < WAYS; k++) begin
        w = (start + k) % WAYS;
        if (pick < 0 && way_q[w].size() > 0 && o_way_ready[w]) begin
          pick = w;
        end
      end
      if (pick >= 0) begin
        rec_out = way_q[pick].pop_front();
        i_din <= '{valid: 1'b1, rec: rec_out};
        i_din_way <= WAY_LOG'(pick);
      end else begin
        i_din <= '0;
      end
    end
    @(negedge CLK);
    i_din <= '0;
  endtask

  // wait for the expected queue to empty and idle a little
  task automatic drain();
    while (expect_q.size() > 0) begin
      @(posedge CLK);
    end
    repeat (10) @(posedge CLK);
  endtask

  initial begin
    RST = 1'b1;
    i_din = '0;
    i_din_way = '0;
    rng = SEED;
    bp_rng = xorshift32(rng);
    repeat (4) @(negedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    assert (o_way_ready == '1 && !o_dout.valid) else begin
      other_errors++;
      $display("tree is not idle after reset");
    end

    new_test("single batch, distinct keys");
    for (int w = 0; w < WAYS; w++) begin
      append_random(way_q[w], rng, N_RAND);
    end
    expect_q = expected_stream(way_q);
    send_all();
    drain();

    // two key ramps with shared keys
    // payload tags tell the ways apart
    new_test("equal keys across ways");
    for (int w = 0; w < WAYS; w++) begin
      append_ramp(way_q[w], key_t'(100), (w % 2 == 0) ? key_t'(10) : key_t'(5),
                  N_EQ, 32'(w) << 16);
    end
    expect_q = expected_stream(way_q);
    send_all();
    drain();

    new_test("uneven ways");
    way_q[1].push_back(terminator_rec());
    append_random(way_q[2], rng, N_LONG);
    for (int w = 0; w < WAYS; w++) begin
      if (w != 1 && w != 2) begin
        append_random(way_q[w], rng, N_RAND);
      end
    end
    expect_q = expected_stream(way_q);
    send_all();
    drain();

    new_test("random back-pressure");
    for (int w = 0; w < WAYS; w++) begin
      append_random(way_q[w], rng, N_RAND);
    end
    expect_q = expected_stream(way_q);
    bp_on = 1'b1;
    send_all();
    drain();
    bp_on = 1'b0;

    // flood way 0 behind a held output until its leaf reports full
    new_test("way readiness");
    append_random(way_q[0], rng, N_FLOOD);
    for (int w = 1; w < WAYS; w++) begin
      append_random(way_q[w], rng, N_RAND);
    end
    expect_q = expected_stream(way_q);
    hold_full = 1'b1;
    repeat (2) @(posedge CLK);
    accepted = 0;
    while (accepted <= 3 * DEPTH && way_q[0].size() > 0) begin
      @(negedge CLK);
      i_din <= '0;
      if (!o_way_ready[0]) begin
        break;
      end
      rec_out = way_q[0].pop_front();
      i_din <= '{valid: 1'b1, rec: rec_out};
      i_din_way <= '0;
      accepted++;
    end
    @(negedge CLK);
    i_din <= '0;
    repeat (4) @(posedge CLK);
    assert (!o_way_ready[0] && accepted <= 3 * DEPTH) else begin
      other_errors++;
      $display("way 0 still ready after %0d accepted beats", accepted);
    end
    hold_full = 1'b0;
    send_all();
    drain();

    new_test("back-to-back batches");
    for (int b = 0; b < N_BATCH; b++) begin
      for (int w = 0; w < WAYS; w++) begin
        append_random(way_q[w], rng, N_RAND);
      end
    end
    expect_q = expected_stream(way_q);
    send_all();
    drain();

    print_summary();
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/merge_tree.sv ====
`default_nettype none

module merge_tree #(
  parameter int WAY_LOG  = 2,
  parameter int FIFO_LOG = 2
) (
  input  wire logic                 CLK,
  input  wire logic                 RST,
  // one record per cycle, steered by way index
  input  wire merge_pkg::beat_t     i_din,
  input  wire logic [WAY_LOG-1:0]   i_din_way,
  output logic [(1<<WAY_LOG)-1:0]   o_way_ready,
  // merged stream out of the root
  output merge_pkg::beat_t          o_dout,
  input  wire logic                 i_out_full
);
  import merge_pkg::*;

  localparam int WAYS  = 1 << WAY_LOG;
  // one link per node output plus one per input way
  localparam int LINKS = 2 * WAYS - 1;

  // links use heap numbering
  // link n carries the output of node n up to node n/2
  // link 1 is the root output, links WAYS.. are the input ways
  beat_t link_beat [1:LINKS];
  // parent FIFO full flag for the same link, seen by the sender
  logic  link_full [1:LINKS];

  // root talks to the outside
  assign o_dout       = link_beat[1];
  assign link_full[1] = i_out_full;

  // input demux onto the leaf links
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    assign link_beat[WAYS+w] = '{
      valid: i_din.valid && (i_din_way == WAY_LOG'(w)),
      rec:   i_din.rec
    };
    // leaf FIFO has room
    assign o_way_ready[w] = ~link_full[WAYS+w];
  end

  // level 0 is the root, level WAY_LOG-1 holds the leaves
  for (genvar lvl = 0; lvl < WAY_LOG; lvl++) begin : g_level
    for (genvar idx = 0; idx < (1 << lvl); idx++) begin : g_node
      // heap number of this node
      localparam int N = (1 << lvl) + idx;

      // children sit on links 2N (left) and 2N+1 (right)
      merge_node #(
        .FIFO_LOG(FIFO_LOG)
      ) node_inst (
        .CLK         (CLK),
        .RST         (RST),
        .i_left      (link_beat[2*N]),
        .i_right     (link_beat[2*N+1]),
        .o_left_full (link_full[2*N]),
        .o_right_full(link_full[2*N+1]),
        .o_out       (link_beat[N]),
        .i_out_full  (link_full[N])
      );
    end
  end

endmodule

`default_nettype wire

// ==== logic/merge_node.sv ====
`default_nettype none

module merge_node #(
  parameter int FIFO_LOG = 2
) (
  input  wire logic             CLK,
  input  wire logic             RST,
  // from the child below on each side
  input  wire merge_pkg::beat_t i_left,
  input  wire merge_pkg::beat_t i_right,
  // back to the children, they hold while set
  output logic                  o_left_full,
  output logic                  o_right_full,
  // up to the parent
  output merge_pkg::beat_t      o_out,
  input  wire logic             i_out_full
);
  import merge_pkg::*;

  record_t head_left;
  record_t head_right;
  logic    empty_left;
  logic    empty_right;
  logic    deq_left;
  logic    deq_right;
  logic    cell_ready;

  // left input buffer
  record_fifo #(
    .FIFO_LOG(FIFO_LOG)
  ) left_fifo (
    .CLK    (CLK),
    .RST    (RST),
    .i_enq  (i_left.valid),
    .i_deq  (deq_left),
    .i_din  (i_left.rec),
    .o_dout (head_left),
    .o_empty(empty_left),
    .o_full (o_left_full)
  );

  // right input buffer
  record_fifo #(
    .FIFO_LOG(FIFO_LOG)
  ) right_fifo (
    .CLK    (CLK),
    .RST    (RST),
    .i_enq  (i_right.valid),
    .i_deq  (deq_right),
    .i_din  (i_right.rec),
    .o_dout (head_right),
    .o_empty(empty_right),
    .o_full (o_right_full)
  );

  // fire only with both heads present and room above
  // the parent FIFO is never tested from this side again
  assign cell_ready = ~empty_left & ~empty_right & ~i_out_full;

  // compare, pick and pop
  sorter_cell cell_inst (
    .i_head0(head_left),
    .i_head1(head_right),
    .i_ready(cell_ready),
    .o_deq0 (deq_left),
    .o_deq1 (deq_right),
    .o_out  (o_out)
  );

endmodule

`default_nettype wire

// ==== logic/sorter_cell.sv ====
`default_nettype none

module sorter_cell (
  input  wire merge_pkg::record_t i_head0,
  input  wire merge_pkg::record_t i_head1,
  input  wire logic               i_ready,
  output logic                    o_deq0,
  output logic                    o_deq1,
  output merge_pkg::beat_t        o_out
);
  import merge_pkg::*;

  key_t key0;
  key_t key1;
  logic left_wins;
  logic both_term;

  assign key0 = i_head0[KEY_W-1:0];
  assign key1 = i_head1[KEY_W-1:0];

  // ties go right, left only on strictly smaller
  assign left_wins = (key0 < key1);

  // end of batch on both sides
  // a lone terminator never wins against a real key, so it waits here
  assign both_term = (key0 == KEY_TERM) && (key1 == KEY_TERM);

  // pop the winner, or both heads at a batch boundary
  assign o_deq0 = i_ready & (left_wins | both_term);
  assign o_deq1 = i_ready & (~left_wins | both_term);

  // on a flush the right terminator goes up
  assign o_out.valid = i_ready;
  assign o_out.rec   = left_wins ? i_head0 : i_head1;

endmodule

`default_nettype wire

// ==== logic/record_fifo.sv ====
`default_nettype none

module record_fifo #(
  parameter int FIFO_LOG = 2
) (
  input  wire logic               CLK,
  input  wire logic               RST,
  input  wire logic               i_enq,
  input  wire logic               i_deq,
  input  wire merge_pkg::record_t i_din,
  output merge_pkg::record_t      o_dout,
  output logic                    o_empty,
  output logic                    o_full
);
  import merge_pkg::*;

  localparam int DEPTH = 1 << FIFO_LOG;

  // distributed storage, head read without a register
  record_t mem [DEPTH];

  logic [FIFO_LOG-1:0] head;
  logic [FIFO_LOG-1:0] tail;
  // one extra bit so full and empty differ
  logic [FIFO_LOG:0]   count;
  logic                do_enq;
  logic                do_deq;

  assign o_empty = (count == '0);
  assign o_full  = (count == (FIFO_LOG+1)'(DEPTH));

  // first word falls through
  assign o_dout = mem[head];

  // a push into a full FIFO is dropped
  assign do_enq = i_enq & ~o_full;
  // popping nothing is ignored
  assign do_deq = i_deq & ~o_empty;

  always_ff @(posedge CLK) begin
    if (do_enq) begin
      mem[tail] <= i_din;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_enq) begin
        tail <= tail + 1'b1;
      end
      if (do_deq) begin
        head <= head + 1'b1;
      end
      // push and pop together keep the count
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/merge_pkg.sv ====
`default_nettype none

package merge_pkg;

  // record layout shared by the whole tree
  parameter int KEY_W  = 32;
  parameter int DATA_W = 64;

  // sort key, low bits of a record
  typedef logic [KEY_W-1:0] key_t;

  // payload on top, key at the bottom
  typedef logic [DATA_W-1:0] record_t;

  // all-ones key closes a batch
  localparam key_t KEY_TERM = '1;

  // record plus its valid bit, one per link
  typedef struct packed {
    logic    valid;
    record_t rec;
  } beat_t;

endpackage

`default_nettype wire
